//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_triangle_store \
    -o tb_triangle_store || exit 1
./obj_dir/tb_triangle_store > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1

//--- src.f
verilog/tri_store_pkg.sv
verilog/single_port_ram.sv
verilog/mem_triangle.sv
verilog/scene_loader.sv
verilog/triangle_fetch.sv
verilog/triangle_store_top.sv
testbench/tb_triangle_store.sv

//--- testbench/tb_triangle_store.sv
`timescale 1ns/10ps
`default_nettype none

module tb_triangle_store;

    import tri_store_pkg::*;

    localparam int tri_a = 40;
    localparam int tri_c = 32;
    localparam int vert_count = 48;
    localparam int single_fetches = 20;
    // words streamed over the three loads including terminators
    localparam int load_words = 2 * (tri_a + vert_count + 2) + (tri_c + vert_count + 2);
    // triangles fetched over all tests
    localparam int fetch_total = tri_a + single_fetches + 11 + tri_a + tri_c;
    localparam int cycle_limit = (load_words + fetch_total) * 8 + 1000;

    logic clk;
    logic rst_n;
    mc_word_t load_word;
    logic load_valid;
    logic load_ready;
    logic fetch_start;
    tri_id_t fetch_first;
    tri_id_t fetch_count;
    logic fetch_busy;
    triangle_t tri_out;
    logic tri_valid;

    // current scene
    int scene_tris;
    coord_t sid_arr [num_triangle];
    coord_t idx_arr [num_triangle][3];
    vertex_t vert_arr [vert_count];

    logic [31:0] rng_state;
    tri_id_t exp_q [$];
    int checks;
    int errors;
    int pulses;
    int test_errors;
    string test_name;
    logic saw_full;
    int cycles;

    triangle_store_top i_triangle_store_top (
        .clk(clk),
        .rst_n(rst_n),
        .load_word(load_word),
        .load_valid(load_valid),
        .load_ready(load_ready),
        .fetch_start(fetch_start),
        .fetch_first(fetch_first),
        .fetch_count(fetch_count),
        .fetch_busy(fetch_busy),
        .tri_out(tri_out),
        .tri_valid(tri_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // vertices looked up through the index table
    function automatic triangle_t expected_triangle(input tri_id_t id);
        triangle_t t;
        t.v0 = vert_arr[idx_arr[id][0]];
        t.v1 = vert_arr[idx_arr[id][1]];
        t.v2 = vert_arr[idx_arr[id][2]];
        t.sid = sid_arr[id];
        return t;
    endfunction

    task automatic check_value(input string name, input logic [319:0] expected,
                               input logic [319:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR in %s: %s", test_name, msg);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic gen_scene(input int ntri);
        int t;
        int k;
        scene_tris = ntri;
        for (t = 0; t < ntri; t++) begin
            // sid of zero would end the index phase
            sid_arr[t] = next_rand() | 32'h1;
            for (k = 0; k < 3; k++) begin
                idx_arr[t][k] = next_rand() % vert_count;
            end
        end
        for (t = 0; t < vert_count; t++) begin
            vert_arr[t] = {next_rand(), next_rand(), next_rand()};
        end
    endtask

    // gap is the number of idle cycles after each accepted word
    task automatic load_scene(input int gap);
        mc_word_t words [$];
        int i;
        int idle_left;
        for (i = 0; i < scene_tris; i++) begin
            words.push_back({sid_arr[i], idx_arr[i][2], idx_arr[i][1], idx_arr[i][0]});
        end
        words.push_back('0);
        for (i = 0; i < vert_count; i++) begin
            words.push_back({next_rand() | 32'h1, vert_arr[i]});
        end
        words.push_back('0);
        saw_full = 1'b0;
        i = 0;
        idle_left = 0;
        while (i < words.size()) begin
            @(negedge clk);
            if (!load_ready) begin
                saw_full = 1'b1;
            end
            if (load_ready && idle_left == 0) begin
                load_valid = 1'b1;
                load_word = words[i];
                i++;
                idle_left = gap;
            end else begin
                load_valid = 1'b0;
                if (idle_left > 0) begin
                    idle_left--;
                end
            end
        end
        @(negedge clk);
        load_valid = 1'b0;
        // memory is back in idle once the loader buffer drains
        while (i_triangle_store_top.u_loader.count != '0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_range(input tri_id_t first, input tri_id_t count);
        int k;
        for (k = 0; k < int'(count); k++) begin
            exp_q.push_back(first + tri_id_t'(k));
        end
        fetch_first = first;
        fetch_count = count;
        fetch_start = 1'b1;
        @(negedge clk);
        fetch_start = 1'b0;
    endtask

    task automatic wait_range();
        while (fetch_busy) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_range();
        @(negedge clk);
        if (exp_q.size() != 0) begin
            report_error($sformatf("range ended with %0d triangles missing", exp_q.size()));
            exp_q.delete();
        end
    endtask

    // compare each delivered triangle against the reference
    initial begin
        tri_id_t id;
        forever begin
            @(negedge clk);
            if (rst_n && tri_valid) begin
                pulses++;
                if (exp_q.size() == 0) begin
                    report_error("tri_valid pulse with no fetch outstanding");
                end else begin
                    id = exp_q.pop_front();
                    check_value($sformatf("%s id %0d", test_name, id),
                                expected_triangle(id), tri_out);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int pulses_before;
        int k;
        rng_state = 32'h0229_f5d1;
        checks = 0;
        errors = 0;
        pulses = 0;
        rst_n = 1'b0;
        load_word = '0;
        load_valid = 1'b0;
        fetch_start = 1'b0;
        fetch_first = '0;
        fetch_count = '0;
        test_name = "reset";
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        begin_test("reset");
        check_value("reset load_ready", 1'b1, load_ready);
        check_value("reset tri_valid", 1'b0, tri_valid);
        check_value("reset fetch_busy", 1'b0, fetch_busy);
        end_test();

        // sequential walk, prefetch hits
        begin_test("range_hit");
        gen_scene(tri_a);
        load_scene(6);
        // idle until the prefetch of id 0 sits in the output buffers
        repeat (8) @(negedge clk);
        pulses_before = pulses;
        start_range('0, tri_id_t'(tri_a));
        wait_range();
        finish_range();
        check_value("range_hit pulse count", tri_a, pulses - pulses_before);
        end_test();

        begin_test("single_miss");
        for (k = 0; k < single_fetches; k++) begin
            start_range(tri_id_t'(next_rand() % scene_tris), tri_id_t'(1));
            wait_range();
            finish_range();
        end
        end_test();

        // prefetch of id 15 is in flight when id 30 is asked for
        begin_test("back_to_back");
        start_range(tri_id_t'(10), tri_id_t'(5));
        wait_range();
        start_range(tri_id_t'(30), tri_id_t'(6));
        wait_range();
        finish_range();
        end_test();

        begin_test("load_backpressure");
        gen_scene(tri_a);
        load_scene(0);
        check_value("load_backpressure load_ready fell", 1'b1, saw_full);
        start_range('0, tri_id_t'(tri_a));
        wait_range();
        finish_range();
        end_test();

        begin_test("reload");
        gen_scene(tri_c);
        load_scene(1);
        start_range('0, tri_id_t'(tri_c));
        wait_range();
        finish_range();
        end_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mem_triangle.sv
`timescale 1ns/10ps
`default_nettype none

module mem_triangle (
    input wire clk,
    input wire rst_n,
    input wire re_ic,
    input wire tri_store_pkg::tri_id_t triangle_id,
    input wire tri_store_pkg::mc_word_t data_mc,
    input wire we_mc,
    output logic rdy_mc,
    output logic rdy_ic,
    output tri_store_pkg::triangle_t triangle
);

    import tri_store_pkg::*;

    typedef enum logic [2:0] {
        idle, mc_wr_index, mc_wr_vertex, rd_0, rd_1, rd_2, rd_sid, rd_done
    } mem_state_t;

    mem_state_t state, state_next;

    // load side
    mc_word_t mc_word;
    logic [2:0] slice_cnt, slice_cnt_next;
    mem_addr_t wr_addr, wr_addr_next;
    logic idx_end, start_wr;

    // ram ports
    logic we_index, we_vertex;
    mem_addr_t index_addr, vertex_addr;
    coord_t index_data, index_q;
    coord_t coord_wr [3];
    coord_t coord_q [3];
    vertex_t vertex_q;
    logic [1:0] rd_slot;

    // read side and prefetch
    tri_id_t rd_id, rd_id_next;
    logic is_pf, is_pf_next;
    logic buf_full, buf_full_next;
    logic req_match, req_miss, rd_busy;
    logic lat_v0, lat_v1, lat_tail;
    logic out_buf, out_buf_next, rdy_ic_next;
    vertex_t v0_buf, v1_buf, v2_buf;
    coord_t sid_buf;

    assign idx_end = (mc_word[mc_word_bits-1 -: coord_bits] == '0);
    assign start_wr = we_mc && (state != mc_wr_index) && (state != mc_wr_vertex);
    assign rd_busy = state inside {rd_0, rd_1, rd_2, rd_sid, rd_done};
    assign req_match = re_ic && (triangle_id == rd_id);
    assign req_miss = re_ic && (triangle_id != rd_id);
    assign index_data = mc_word[{slice_cnt[1:0], 5'd0} +: coord_bits];

    // index slot read in each read state
    always_comb begin
        case (state)
            rd_1: rd_slot = 2'd1;
            rd_2: rd_slot = 2'd2;
            rd_sid: rd_slot = 2'd3;
            default: rd_slot = 2'd0;
        endcase
    end

    always_comb begin
        state_next = state;
        slice_cnt_next = slice_cnt;
        wr_addr_next = wr_addr;
        rd_id_next = rd_id;
        // a matching request turns a prefetch into a demand read
        is_pf_next = is_pf && !req_match;
        buf_full_next = buf_full;
        rdy_ic_next = 1'b0;
        out_buf_next = 1'b0;
        rdy_mc = 1'b0;
        we_index = 1'b0;
        we_vertex = 1'b0;
        lat_v0 = 1'b0;
        lat_v1 = 1'b0;
        lat_tail = 1'b0;
        index_addr = {rd_id, rd_slot};
        vertex_addr = index_q[mem_depth_bits-1:0];
        case (state)
            idle: begin
                if (req_match && buf_full) begin
                    // hit: answer from buffers, prefetch the next id
                    rdy_ic_next = 1'b1;
                    out_buf_next = 1'b1;
                    rd_id_next = rd_id + tri_id_t'(1);
                    is_pf_next = 1'b1;
                    buf_full_next = 1'b0;
                    state_next = rd_0;
                end else if (re_ic) begin
                    rd_id_next = triangle_id;
                    is_pf_next = 1'b0;
                    buf_full_next = 1'b0;
                    state_next = rd_0;
                end else if (!buf_full) begin
                    rd_id_next = rd_id + tri_id_t'(1);
                    is_pf_next = 1'b1;
                    state_next = rd_0;
                end
            end
            mc_wr_index: begin
                if (!we_mc && slice_cnt != 3'd4) begin
                    slice_cnt_next = slice_cnt + 3'd1;
                    index_addr = wr_addr;
                    // terminator word is not stored
                    we_index = !idx_end;
                    if (!idx_end) begin
                        wr_addr_next = wr_addr + mem_addr_t'(1);
                    end
                    if (slice_cnt == 3'd3) begin
                        rdy_mc = 1'b1;
                        if (idx_end) begin
                            wr_addr_next = '0;
                            state_next = mc_wr_vertex;
                        end
                    end
                end
            end
            mc_wr_vertex: begin
                if (we_mc) begin
                    rdy_mc = 1'b1;
                    if (data_mc[mc_word_bits-1 -: coord_bits] == '0) begin
                        // arm prefetch so id 0 comes next
                        rd_id_next = '1;
                        is_pf_next = 1'b0;
                        buf_full_next = 1'b0;
                        state_next = idle;
                    end else begin
                        we_vertex = 1'b1;
                        vertex_addr = wr_addr;
                        wr_addr_next = wr_addr + mem_addr_t'(1);
                    end
                end
            end
            rd_0: state_next = rd_1;
            rd_1: state_next = rd_2;
            rd_2: begin
                lat_v0 = 1'b1;
                state_next = rd_sid;
            end
            rd_sid: begin
                lat_v1 = 1'b1;
                if (!is_pf || req_match) begin
                    // v2 and sid go out straight from the rams
                    rdy_ic_next = 1'b1;
                    is_pf_next = 1'b0;
                    state_next = idle;
                end else begin
                    state_next = rd_done;
                end
            end
            rd_done: begin
                lat_tail = 1'b1;
                if (req_match) begin
                    rdy_ic_next = 1'b1;
                    out_buf_next = 1'b1;
                    rd_id_next = rd_id + tri_id_t'(1);
                    is_pf_next = 1'b1;
                    state_next = rd_0;
                end else begin
                    buf_full_next = 1'b1;
                    is_pf_next = 1'b0;
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
        // request for another id: drop the prefetch and restart
        if (rd_busy && req_miss) begin
            rd_id_next = triangle_id;
            is_pf_next = 1'b0;
            buf_full_next = 1'b0;
            rdy_ic_next = 1'b0;
            out_buf_next = 1'b0;
            state_next = rd_0;
        end
        if (we_mc) begin
            slice_cnt_next = 3'd0;
        end
        if (start_wr) begin
            wr_addr_next = '0;
            is_pf_next = 1'b0;
            buf_full_next = 1'b0;
            rdy_ic_next = 1'b0;
            out_buf_next = 1'b0;
            state_next = mc_wr_index;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            slice_cnt <= 3'd4;
            wr_addr <= '0;
            rd_id <= '1;
            is_pf <= 1'b0;
            buf_full <= 1'b0;
            rdy_ic <= 1'b0;
            out_buf <= 1'b0;
        end else begin
            state <= state_next;
            slice_cnt <= slice_cnt_next;
            wr_addr <= wr_addr_next;
            rd_id <= rd_id_next;
            is_pf <= is_pf_next;
            buf_full <= buf_full_next;
            rdy_ic <= rdy_ic_next;
            out_buf <= out_buf_next;
        end
    end

    always_ff @(posedge clk) begin
        if (we_mc) begin
            mc_word <= data_mc;
        end
        if (lat_v0) begin
            v0_buf <= vertex_q;
        end
        if (lat_v1) begin
            v1_buf <= vertex_q;
        end
        if (lat_tail) begin
            v2_buf <= vertex_q;
            sid_buf <= index_q;
        end
    end

    single_port_ram #(.addr_width(mem_depth_bits), .data_width(coord_bits)) u_index_ram (
        .clk(clk),
        .we(we_index),
        .data(index_data),
        .addr(index_addr),
        .q(index_q)
    );

    // 0 is x, 1 is y, 2 is z
    for (genvar i = 0; i < 3; i++) begin : g_coord_ram
        assign coord_wr[i] = data_mc[i*coord_bits +: coord_bits];
        single_port_ram #(.addr_width(mem_depth_bits), .data_width(coord_bits)) u_ram (
            .clk(clk),
            .we(we_vertex),
            .data(coord_wr[i]),
            .addr(vertex_addr),
            .q(coord_q[i])
        );
    end

    assign vertex_q = {coord_q[2], coord_q[1], coord_q[0]};

    always_comb begin
        triangle.v0 = v0_buf;
        triangle.v1 = v1_buf;
        triangle.v2 = out_buf ? v2_buf : vertex_q;
        triangle.sid = out_buf ? sid_buf : index_q;
    end

endmodule

`default_nettype wire

//--- verilog/scene_loader.sv
`timescale 1ns/10ps
`default_nettype none

module scene_loader (
    input wire clk,
    input wire rst_n,
    input wire tri_store_pkg::mc_word_t load_word,
    input wire load_valid,
    output logic load_ready,
    output tri_store_pkg::mc_word_t data_mc,
    output logic we_mc,
    input wire rdy_mc
);

    import tri_store_pkg::*;

    typedef enum logic {send, wait_rdy} ld_state_t;

    ld_state_t state;
    mc_word_t word_buf [loader_depth];
    logic [loader_ptr_bits-1:0] wr_ptr, rd_ptr;
    logic [loader_ptr_bits:0] count;
    logic push, pop;

    assign load_ready = (count != loader_depth[loader_ptr_bits:0]);
    assign push = load_valid && load_ready;
    assign we_mc = (state == send) && (count != '0);
    assign data_mc = word_buf[rd_ptr];
    // vertex words are acked in the strobe cycle
    assign pop = rdy_mc && ((state == wait_rdy) || we_mc);

    always_ff @(posedge clk) begin
        if (push) begin
            word_buf[wr_ptr] <= load_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= send;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            if (pop) begin
                state <= send;
            end else if (we_mc) begin
                state <= wait_rdy;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/single_port_ram.sv
`timescale 1ns/10ps
`default_nettype none

module single_port_ram #(
    parameter int addr_width = 11,
    parameter int data_width = 32
) (
    input wire clk,
    input wire we,
    input wire [data_width-1:0] data,
    input wire [addr_width-1:0] addr,
    output logic [data_width-1:0] q
);

    logic [data_width-1:0] mem [0:(1 << addr_width)-1];

    // read returns the old word on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];
    end

endmodule

`default_nettype wire

//--- verilog/tri_store_pkg.sv
`default_nettype none

package tri_store_pkg;

    // scene size
    localparam int num_triangle = 512;
    localparam int tri_bits = $clog2(num_triangle);
    // four index slots per triangle
    localparam int mem_depth_bits = tri_bits + 2;

    localparam int coord_bits = 32;
    localparam int mc_word_bits = 128;

    // host word buffer in the loader
    localparam int loader_depth = 4;
    localparam int loader_ptr_bits = $clog2(loader_depth);

    typedef logic [tri_bits-1:0] tri_id_t;
    typedef logic [mem_depth_bits-1:0] mem_addr_t;
    typedef logic [coord_bits-1:0] coord_t;
    typedef logic [mc_word_bits-1:0] mc_word_t;

    // x sits in the low word
    typedef struct packed {
        coord_t z;
        coord_t y;
        coord_t x;
    } vertex_t;

    typedef struct packed {
        coord_t sid;
        vertex_t v2;
        vertex_t v1;
        vertex_t v0;
    } triangle_t;

endpackage

`default_nettype wire

//--- verilog/triangle_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module triangle_fetch (
    input wire clk,
    input wire rst_n,
    input wire fetch_start,
    input wire tri_store_pkg::tri_id_t fetch_first,
    input wire tri_store_pkg::tri_id_t fetch_count,
    output logic fetch_busy,
    output logic re_ic,
    output tri_store_pkg::tri_id_t triangle_id,
    input wire rdy_ic,
    input wire tri_store_pkg::triangle_t triangle,
    output tri_store_pkg::triangle_t tri_out,
    output logic tri_valid
);

    import tri_store_pkg::*;

    typedef enum logic [1:0] {idle, issue, wait_rdy} fetch_state_t;

    fetch_state_t state;
    tri_id_t cur_id;
    tri_id_t remaining;

    assign fetch_busy = (state != idle);
    assign re_ic = (state == issue);
    // held steady until the answer
    assign triangle_id = cur_id;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            cur_id <= '0;
            remaining <= '0;
            tri_valid <= 1'b0;
        end else begin
            tri_valid <= 1'b0;
            case (state)
                idle: begin
                    if (fetch_start) begin
                        cur_id <= fetch_first;
                        remaining <= fetch_count;
                        state <= issue;
                    end
                end
                issue: state <= wait_rdy;
                wait_rdy: begin
                    if (rdy_ic) begin
                        tri_valid <= 1'b1;
                        cur_id <= cur_id + tri_id_t'(1);
                        remaining <= remaining - tri_id_t'(1);
                        // last one of the range
                        state <= (remaining == tri_id_t'(1)) ? idle : issue;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == wait_rdy && rdy_ic) begin
            tri_out <= triangle;
        end
    end

endmodule

`default_nettype wire

//--- verilog/triangle_store_top.sv
`timescale 1ns/10ps
`default_nettype none

module triangle_store_top (
    input wire clk,
    input wire rst_n,
    input wire tri_store_pkg::mc_word_t load_word,
    input wire load_valid,
    output logic load_ready,
    input wire fetch_start,
    input wire tri_store_pkg::tri_id_t fetch_first,
    input wire tri_store_pkg::tri_id_t fetch_count,
    output logic fetch_busy,
    output tri_store_pkg::triangle_t tri_out,
    output logic tri_valid
);

    import tri_store_pkg::*;

    // loader to memory
    mc_word_t data_mc;
    logic we_mc, rdy_mc;
    // fetcher to memory
    logic re_ic, rdy_ic;
    tri_id_t triangle_id;
    triangle_t triangle;

    scene_loader u_loader (
        .clk(clk),
        .rst_n(rst_n),
        .load_word(load_word),
        .load_valid(load_valid),
        .load_ready(load_ready),
        .data_mc(data_mc),
        .we_mc(we_mc),
        .rdy_mc(rdy_mc)
    );

    mem_triangle u_mem (
        .clk(clk),
        .rst_n(rst_n),
        .re_ic(re_ic),
        .triangle_id(triangle_id),
        .data_mc(data_mc),
        .we_mc(we_mc),
        .rdy_mc(rdy_mc),
        .rdy_ic(rdy_ic),
        .triangle(triangle)
    );

    triangle_fetch u_fetch (
        .clk(clk),
        .rst_n(rst_n),
        .fetch_start(fetch_start),
        .fetch_first(fetch_first),
        .fetch_count(fetch_count),
        .fetch_busy(fetch_busy),
        .re_ic(re_ic),
        .triangle_id(triangle_id),
        .rdy_ic(rdy_ic),
        .triangle(triangle),
        .tri_out(tri_out),
        .tri_valid(tri_valid)
    );

endmodule

`default_nettype wire
